// ==== list.f ====
+incdir+include
logic/mem_pkg.sv
logic/exec_latch.sv
logic/memory_stage.sv
logic/load_unit.sv
logic/data_memory.sv
logic/mem_subsystem.sv
dv/mem_asserts.sv
dv/mem_tb.sv

// ==== dv/mem_trace.txt ====
# name op addr sdata waddr wdata clear expected_wb (hex, or none)
# op is ALU LB LH LW LBU LHU SB SH SW, all numbers hex except clear
alu_basic      ALU 00000000 00000000 01 12345678 0 12345678
alu_x0         ALU 00000000 00000000 00 deadbeef 0 none
sw_word        SW  00000010 a5b6c7d8 1e 00000000 0 none
lw_word        LW  00000010 00000000 02 00000000 0 a5b6c7d8
lw_x0          LW  00000010 00000000 00 00000000 0 none
sw_base        SW  00000020 11223344 00 00000000 0 none
sb_off0        SB  00000020 123456f0 00 00000000 0 none
sb_off1        SB  00000021 ffffff81 00 00000000 0 none
sb_off2        SB  00000022 abcdef7e 00 00000000 0 none
sb_off3        SB  00000023 000000c3 00 00000000 0 none
lw_merged      LW  00000020 00000000 03 00000000 0 c37e81f0
lb_off0        LB  00000020 00000000 04 00000000 0 fffffff0
lbu_off1       LBU 00000021 00000000 05 00000000 0 00000081
lb_off1        LB  00000021 00000000 06 00000000 0 ffffff81
lb_off2        LB  00000022 00000000 07 00000000 0 0000007e
lbu_off3       LBU 00000023 00000000 08 00000000 0 000000c3
lhu_off0       LHU 00000020 00000000 10 00000000 0 000081f0
lh_off2        LH  00000022 00000000 11 00000000 0 ffffc37e
sh_low         SH  00000030 ffff8001 00 00000000 0 none
sh_high        SH  00000032 12347ffe 00 00000000 0 none
lh_low         LH  00000030 00000000 09 00000000 0 ffff8001
lhu_low        LHU 00000030 00000000 0a 00000000 0 00008001
lh_high        LH  00000032 00000000 0b 00000000 0 00007ffe
lw_half        LW  00000030 00000000 0c 00000000 0 7ffe8001
alu_clear      ALU 00000000 00000000 0d cafef00d 1 none
lw_clear       LW  00000010 00000000 0e 00000000 1 none
sw_clear       SW  00000040 5a5a1234 00 00000000 1 none
lw_after_clear LW  00000040 00000000 0f 00000000 0 5a5a1234
alu_last       ALU 00000000 00000000 1f 0badf00d 0 0badf00d

// ==== dv/mem_tb.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_tb;

  typedef struct {
    string            name;
    mem_pkg::lsu_op_t op;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] sdata;
    logic [4:0]       waddr;
    logic [`XLEN-1:0] wdata;
    logic             clr;
    logic             has_wb;
    logic [`XLEN-1:0] wb_val;
  } trace_op_t;

  typedef struct {
    string            name;
    logic [4:0]       waddr;
    logic [`XLEN-1:0] data;
  } exp_wb_t;

  logic               clk = 1'b0;
  logic               rst;
  logic               in_valid;
  mem_pkg::lsu_op_t   in_op;
  logic [`XLEN-1:0]   in_addr;
  logic [`XLEN-1:0]   in_sdata;
  logic [4:0]         in_waddr;
  logic [`XLEN-1:0]   in_wdata;
  logic               clear;
  logic               stall;
  logic               wb_wren;
  logic [4:0]         wb_waddr;
  logic [`XLEN-1:0]   wb_wdata;

  trace_op_t   ops[$];
  exp_wb_t     exp_q[$];
  logic [31:0] lfsr_state = 32'h447128b6;
  logic        trace_loaded = 1'b0;
  int          mismatch_count = 0;
  int          missing_count = 0;
  int          unexpected_count = 0;
  int          other_count = 0;

  mem_subsystem i_mem_subsystem (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op),
    .in_addr(in_addr), .in_sdata(in_sdata), .in_waddr(in_waddr),
    .in_wdata(in_wdata), .clear(clear), .stall(stall), .wb_wren(wb_wren),
    .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
  );

  bind memory_stage mem_asserts i_mem_asserts (
    .clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
    .stall(stall), .wb_wren(wb_wren), .wb_waddr(wb_waddr)
  );

  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic int idle_gap();
    int gap;
    lfsr_state = lfsr_next(lfsr_state);
    gap = int'(lfsr_state[0]);
    lfsr_state = lfsr_next(lfsr_state);
    gap = gap + 2 * int'(lfsr_state[0]);
    return gap;
  endfunction

  function automatic logic decode_op(input string s, output mem_pkg::lsu_op_t op);
    decode_op = 1'b1;
    case (s)
      "ALU":   op = mem_pkg::OP_ALU;
      "LB":    op = mem_pkg::OP_LB;
      "LH":    op = mem_pkg::OP_LH;
      "LW":    op = mem_pkg::OP_LW;
      "LBU":   op = mem_pkg::OP_LBU;
      "LHU":   op = mem_pkg::OP_LHU;
      "SB":    op = mem_pkg::OP_SB;
      "SH":    op = mem_pkg::OP_SH;
      "SW":    op = mem_pkg::OP_SW;
      default: begin
        op = mem_pkg::OP_ALU;
        decode_op = 1'b0;
      end
    endcase
  endfunction

  task automatic load_trace();
    int               fd;
    int               n;
    int               clr_i;
    string            line;
    string            name_s;
    string            op_s;
    string            exp_s;
    logic [`XLEN-1:0] addr_v;
    logic [`XLEN-1:0] sdata_v;
    logic [`XLEN-1:0] wdata_v;
    logic [4:0]       waddr_v;
    mem_pkg::lsu_op_t op_v;
    trace_op_t        t;
    fd = $fopen("dv/mem_trace.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("could not open trace file dv/mem_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 1) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%s %s %h %h %h %h %d %s", name_s, op_s, addr_v, sdata_v,
                      waddr_v, wdata_v, clr_i, exp_s);
          if ((n != 8) || !decode_op(op_s, op_v)) begin
            other_count++;
            $display("malformed trace line: %s", line);
          end else begin
            t.name   = name_s;
            t.op     = op_v;
            t.addr   = addr_v;
            t.sdata  = sdata_v;
            t.waddr  = waddr_v;
            t.wdata  = wdata_v;
            t.clr    = (clr_i != 0);
            t.has_wb = (exp_s != "none");
            t.wb_val = '0;
            if (t.has_wb) begin
              void'($sscanf(exp_s, "%h", t.wb_val));
            end
            ops.push_back(t);
          end
        end
      end
      $fclose(fd);
      if (ops.size() == 0) begin
        other_count++;
        $display("trace file holds no operations");
      end
    end
    trace_loaded = 1'b1;
  endtask

  // present one op, hold it until taken, then pulse clear if asked
  task automatic send_op(input trace_op_t t);
    logic    taken;
    logic    exp_stall;
    exp_wb_t e;
    @(negedge clk);
    while (stall == 1'b1) @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b1;
    in_op    <= t.op;
    in_addr  <= t.addr;
    in_sdata <= t.sdata;
    in_waddr <= t.waddr;
    in_wdata <= t.wdata;
    if (t.has_wb) begin
      e.name  = t.name;
      e.waddr = t.waddr;
      e.data  = t.wb_val;
      exp_q.push_back(e);
    end
    taken = 1'b0;
    while (taken == 1'b0) begin
      @(negedge clk);
      taken = (stall == 1'b0);
      @(posedge clk);
    end
    in_valid <= 1'b0;
    clear    <= t.clr;
    exp_stall = (t.op != mem_pkg::OP_ALU);
    @(negedge clk);
    assert (stall == exp_stall) else begin
      mismatch_count++;
      $display("Mismatch %s stall: expected %0b, actual %0b", t.name, exp_stall, stall);
    end
    @(posedge clk);
    clear <= 1'b0;
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatch, %0d missing, %0d unexpected, %0d other",
             mismatch_count, missing_count, unexpected_count, other_count);
  endtask

  always @(negedge clk) begin : wb_monitor
    exp_wb_t cur;
    if ((rst == 1'b1) && (wb_wren == 1'b1)) begin
      assert (exp_q.size() != 0) else begin
        unexpected_count++;
        $display("write-back to x%0d of %h when no result was expected", wb_waddr, wb_wdata);
      end
      if (exp_q.size() != 0) begin
        cur = exp_q.pop_front();
        assert (wb_waddr == cur.waddr) else begin
          mismatch_count++;
          $display("Mismatch %s waddr: expected %0d, actual %0d", cur.name, cur.waddr,
                   wb_waddr);
        end
        assert (wb_wdata == cur.data) else begin
          mismatch_count++;
          $display("Mismatch %s wdata: expected %h, actual %h", cur.name, cur.data, wb_wdata);
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (trace_loaded == 1'b1);
    limit = ops.size() * (`MEM_WAIT + 8) + 100;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, the trace did not complete", limit);
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int gap;
    int drain;
    rst      = 1'b0;
    in_valid = 1'b0;
    in_op    = mem_pkg::OP_ALU;
    in_addr  = '0;
    in_sdata = '0;
    in_waddr = '0;
    in_wdata = '0;
    clear    = 1'b0;
    load_trace();
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    foreach (ops[i]) begin
      gap = idle_gap();
      repeat (gap) @(posedge clk);
      send_op(ops[i]);
    end
    // let the last access finish
    drain = 0;
    @(negedge clk);
    while (((exp_q.size() != 0) || (stall == 1'b1)) && (drain < `MEM_WAIT + 8)) begin
      @(negedge clk);
      drain++;
    end
    repeat (2) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      foreach (exp_q[i]) begin
        missing_count++;
        $display("%s expected a write-back to x%0d but none came", exp_q[i].name,
                 exp_q[i].waddr);
      end
    end
    print_counts();
    if ((mismatch_count + missing_count + unexpected_count + other_count) == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/mem_asserts.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_asserts (
  input logic               clk,
  input logic               rst,
  input logic               mem_valid,
  input logic [`XLEN-1:0]   mem_addr,
  input logic [`XLEN-1:0]   mem_wdata,
  input logic [3:0]         mem_wstrb,
  input logic               mem_ready,
  input logic               stall,
  input logic               wb_wren,
  input logic [4:0]         wb_waddr
);

  // request and its fields frozen until ready
  req_held: assert property (@(posedge clk) disable iff (!rst)
    (mem_valid && !mem_ready) |=>
      (mem_valid && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_wstrb)))
    else $error("memory request dropped or changed before ready");

  // a stall ends only in the ready cycle
  stall_until_ready: assert property (@(posedge clk) disable iff (!rst)
    stall |=> (stall || mem_ready))
    else $error("stall dropped before the memory answered");

  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    wb_wren |-> (wb_waddr != 5'd0))
    else $error("write-back to register 0");

  reset_quiet: assert property (@(posedge clk)
    !rst |=> (!stall && !wb_wren))
    else $error("stall or write-back active after reset");

endmodule

// ==== logic/mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  mem_pkg::lsu_op_t   in_op,
  input  logic [`XLEN-1:0]   in_addr,
  input  logic [`XLEN-1:0]   in_sdata,
  input  logic [4:0]         in_waddr,
  input  logic [`XLEN-1:0]   in_wdata,
  input  logic               clear,
  output logic               stall,
  output logic               wb_wren,
  output logic [4:0]         wb_waddr,
  output logic [`XLEN-1:0]   wb_wdata
);

  logic               x_valid;
  mem_pkg::lsu_op_t   x_op;
  logic [`XLEN-1:0]   x_addr;
  logic [`XLEN-1:0]   x_sdata;
  logic [4:0]         x_waddr;
  logic [`XLEN-1:0]   x_wdata;
  logic               done;
  logic               mem_valid;
  logic [`XLEN-1:0]   mem_addr;
  logic [`XLEN-1:0]   mem_wdata;
  logic [3:0]         mem_wstrb;
  logic               mem_ready;
  logic [`XLEN-1:0]   mem_rdata;
  logic [`XLEN-1:0]   ld_result;

  exec_latch i_exec_latch (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op),
    .in_addr(in_addr), .in_sdata(in_sdata), .in_waddr(in_waddr),
    .in_wdata(in_wdata), .stall(stall), .done(done),
    .x_valid(x_valid), .x_op(x_op), .x_addr(x_addr), .x_sdata(x_sdata),
    .x_waddr(x_waddr), .x_wdata(x_wdata)
  );

  memory_stage i_memory_stage (
    .clk(clk), .rst(rst), .clear(clear), .x_valid(x_valid), .x_op(x_op),
    .x_addr(x_addr), .x_sdata(x_sdata), .x_waddr(x_waddr), .x_wdata(x_wdata),
    .mem_ready(mem_ready), .ld_result(ld_result), .stall(stall), .done(done),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .wb_wren(wb_wren), .wb_waddr(wb_waddr),
    .wb_wdata(wb_wdata)
  );

  load_unit i_load_unit (
    .x_op(x_op), .byte_off(x_addr[1:0]), .mem_rdata(mem_rdata),
    .ld_result(ld_result)
  );

  data_memory i_data_memory (
    .clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module data_memory (
  input  logic               clk,
  input  logic               rst,
  input  logic               mem_valid,
  input  logic [`XLEN-1:0]   mem_addr,
  input  logic [`XLEN-1:0]   mem_wdata,
  input  logic [3:0]         mem_wstrb,
  output logic               mem_ready,
  output logic [`XLEN-1:0]   mem_rdata
);

  localparam int AW = $clog2(`DMEM_DEPTH);
  localparam int CW = $clog2(`MEM_WAIT + 1);

  logic [`XLEN-1:0] mem [`DMEM_DEPTH];
  mem_pkg::mem_state_t state;
  logic [CW-1:0] wait_cnt;
  logic [AW-1:0] word_addr;

  assign word_addr = mem_addr[AW+1:2];

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      state     <= mem_pkg::MS_IDLE;
      wait_cnt  <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= 1'b0;
      case (state)
        mem_pkg::MS_IDLE: begin
          // request still high during the ready cycle is the old one
          if ((mem_valid == 1'b1) && (mem_ready == 1'b0)) begin
            state    <= mem_pkg::MS_BUSY;
            wait_cnt <= '0;
          end
        end
        default: begin
          if (wait_cnt == CW'(`MEM_WAIT - 1)) begin
            state     <= mem_pkg::MS_IDLE;
            mem_ready <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // access happens on the edge that raises ready
  always_ff @(posedge clk) begin
    if ((state == mem_pkg::MS_BUSY) && (wait_cnt == CW'(`MEM_WAIT - 1))) begin
      mem_rdata <= mem[word_addr];
      for (int i = 0; i < 4; i++) begin
        if (mem_wstrb[i] == 1'b1) begin
          mem[word_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== logic/load_unit.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module load_unit (
  input  mem_pkg::lsu_op_t   x_op,
  input  logic [1:0]         byte_off,
  input  logic [`XLEN-1:0]   mem_rdata,
  output logic [`XLEN-1:0]   ld_result
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // pick the addressed lane
  always_comb begin
    case (byte_off)
      2'd0:    ld_byte = mem_rdata[7:0];
      2'd1:    ld_byte = mem_rdata[15:8];
      2'd2:    ld_byte = mem_rdata[23:16];
      default: ld_byte = mem_rdata[31:24];
    endcase
  end

  assign ld_half = byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (x_op)
      mem_pkg::OP_LB:  ld_result = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
      mem_pkg::OP_LBU: ld_result = {{(`XLEN-8){1'b0}}, ld_byte};
      mem_pkg::OP_LH:  ld_result = {{(`XLEN-16){ld_half[15]}}, ld_half};
      mem_pkg::OP_LHU: ld_result = {{(`XLEN-16){1'b0}}, ld_half};
      default:         ld_result = mem_rdata;
    endcase
  end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module memory_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  input  logic               x_valid,
  input  mem_pkg::lsu_op_t   x_op,
  input  logic [`XLEN-1:0]   x_addr,
  input  logic [`XLEN-1:0]   x_sdata,
  input  logic [4:0]         x_waddr,
  input  logic [`XLEN-1:0]   x_wdata,
  input  logic               mem_ready,
  input  logic [`XLEN-1:0]   ld_result,
  output logic               stall,
  output logic               done,
  output logic               mem_valid,
  output logic [`XLEN-1:0]   mem_addr,
  output logic [`XLEN-1:0]   mem_wdata,
  output logic [3:0]         mem_wstrb,
  output logic               wb_wren,
  output logic [4:0]         wb_waddr,
  output logic [`XLEN-1:0]   wb_wdata
);

  logic is_load;
  logic is_store;
  logic is_mem;
  logic kill_q;
  logic kill;
  logic [1:0] byte_off;

  assign is_load  = mem_pkg::is_load_op(x_op);
  assign is_store = mem_pkg::is_store_op(x_op);
  assign is_mem   = x_valid & (is_load | is_store);
  assign byte_off = x_addr[1:0];

  // request held until the memory answers
  assign mem_valid = is_mem;
  assign mem_addr  = x_addr;
  assign stall     = is_mem & ~mem_ready;
  assign done      = x_valid & (~(is_load | is_store) | mem_ready);

  // replicate store data over the byte lanes
  always_comb begin
    case (x_op)
      mem_pkg::OP_SB: mem_wdata = {4{x_sdata[7:0]}};
      mem_pkg::OP_SH: mem_wdata = {2{x_sdata[15:0]}};
      default:        mem_wdata = x_sdata;
    endcase
  end

  always_comb begin
    case (x_op)
      mem_pkg::OP_SB: mem_wstrb = 4'b0001 << byte_off;
      mem_pkg::OP_SH: mem_wstrb = byte_off[1] ? 4'b1100 : 4'b0011;
      mem_pkg::OP_SW: mem_wstrb = 4'b1111;
      default:        mem_wstrb = 4'b0000;
    endcase
  end

  // a clear seen in any cycle of the op kills its write-back
  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      kill_q <= 1'b0;
    end else if (done == 1'b1) begin
      kill_q <= 1'b0;
    end else if ((clear == 1'b1) && (x_valid == 1'b1)) begin
      kill_q <= 1'b1;
    end
  end

  assign kill = kill_q | clear;

  // x0 is never written
  assign wb_wren = x_valid & ~kill & (x_waddr != 5'd0) &
                   (~(is_load | is_store) | (is_load & mem_ready));
  assign wb_waddr = x_waddr;
  assign wb_wdata = is_load ? ld_result : x_wdata;

endmodule

// ==== logic/exec_latch.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module exec_latch (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  mem_pkg::lsu_op_t   in_op,
  input  logic [`XLEN-1:0]   in_addr,
  input  logic [`XLEN-1:0]   in_sdata,
  input  logic [4:0]         in_waddr,
  input  logic [`XLEN-1:0]   in_wdata,
  input  logic               stall,
  input  logic               done,
  output logic               x_valid,
  output mem_pkg::lsu_op_t   x_op,
  output logic [`XLEN-1:0]   x_addr,
  output logic [`XLEN-1:0]   x_sdata,
  output logic [4:0]         x_waddr,
  output logic [`XLEN-1:0]   x_wdata
);

  // valid and op steer the decode downstream
  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      x_valid <= 1'b0;
      x_op    <= mem_pkg::OP_ALU;
    end else if (stall == 1'b0) begin
      if (in_valid == 1'b1) begin
        x_valid <= 1'b1;
        x_op    <= in_op;
      end else if (done == 1'b1) begin
        // finished op must not run twice
        x_valid <= 1'b0;
      end
    end
  end

  // operands only move on a fresh operation
  always_ff @(posedge clk) begin
    if ((stall == 1'b0) && (in_valid == 1'b1)) begin
      x_addr  <= in_addr;
      x_sdata <= in_sdata;
      x_waddr <= in_waddr;
      x_wdata <= in_wdata;
    end
  end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // operation carried from the execute stage
  typedef enum logic [3:0] {
    OP_ALU,
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } lsu_op_t;

  // data memory handshake state
  typedef enum logic {
    MS_IDLE,
    MS_BUSY
  } mem_state_t;

  function automatic logic is_load_op(input lsu_op_t op);
    return (op == OP_LB) || (op == OP_LH) || (op == OP_LW) ||
           (op == OP_LBU) || (op == OP_LHU);
  endfunction

  function automatic logic is_store_op(input lsu_op_t op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

endpackage

// ==== include/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data and address width
`define XLEN 32

// data memory size in 32-bit words
`define DMEM_DEPTH 256

// wait cycles before the memory answers a request
`define MEM_WAIT 2

`endif
